/* vlog.f */
+incdir+design
design/hub_pkg.sv
design/stream_if.sv
design/stream_merge.sv
design/stream_fanout.sv
design/packet_hub.sv
bench/tb_packet_hub.sv

/* run.sh */
#!/bin/sh
# Verilator build and run of tb_packet_hub, verdict taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f vlog.f --top-module tb_packet_hub \
    -o tb_packet_hub \
    && ./obj_dir/tb_packet_hub > sim.log 2>&1
grep -q "Simulation completed successfully" sim.log \
    && echo "PASS" \
    || { echo "FAIL, see sim.log"; exit 1; }

/* bench/tb_packet_hub.sv */
// --------------------
// Random stimulus from a fixed seed on one clock
// Packets of 1 to 8 beats with random gaps and ready
// host_rx beats are matched to a port by their source code
// --------------------
`timescale 1ns/1ps
`include "hub_config.svh"

module tb_packet_hub;
    import hub_pkg::*;

    localparam int N_STREAM       = 6;      // Packets per port in back-to-back phase
    localparam int N_RANDOM       = 8;      // Packets per port in random phase
    localparam int N_TX           = 12;     // Host transmit packets
    localparam int MAX_BEATS      = (2 * (1 + N_STREAM + N_RANDOM) + N_TX) * 8;
    localparam int TIMEOUT_CYCLES = MAX_BEATS * 20 + 1000;

    logic                   clk;
    logic                   rst;
    logic [`HUB_DATA_W-1:0] a_rx_tdata, d_rx_tdata, host_rx_tdata;
    logic [`HUB_DATA_W-1:0] host_tx_tdata, a_tx_tdata, d_tx_tdata;
    logic [`HUB_STRB_W-1:0] a_rx_tstrb, d_rx_tstrb, host_rx_tstrb;
    logic [`HUB_STRB_W-1:0] host_tx_tstrb, a_tx_tstrb, d_tx_tstrb;
    logic [`HUB_USER_W-1:0] a_rx_tuser, d_rx_tuser, host_rx_tuser;
    logic [`HUB_USER_W-1:0] host_tx_tuser, a_tx_tuser, d_tx_tuser;
    logic a_rx_tlast, d_rx_tlast, host_rx_tlast, host_tx_tlast, a_tx_tlast, d_tx_tlast;
    logic a_rx_tvalid, d_rx_tvalid, host_rx_tvalid, host_tx_tvalid, a_tx_tvalid, d_tx_tvalid;
    logic a_rx_tready, d_rx_tready, host_rx_tready, host_tx_tready, a_tx_tready, d_tx_tready;

    integer     seed = 91578;               // Shared by every random draw
    int         mismatch_count = 0;
    int         other_count = 0;
    logic       rx_ready_random = 1'b0;     // host_rx_tready toggles when set
    logic       alternate_on = 1'b0;        // Set while both ports are busy
    logic       rx_in_packet = 1'b0;        // host_rx between first beat and tlast
    logic       rx_have_last = 1'b0;
    logic [7:0] rx_cur_src;
    logic [7:0] rx_last_src;                // Source code of the previous packet

    beat_t exp_a_q[$];                      // host_rx beats expected from port A
    beat_t exp_d_q[$];                      // host_rx beats expected from port D
    beat_t exp_atx_q[$];                    // a_tx beats expected
    beat_t exp_dtx_q[$];                    // d_tx beats expected

    packet_hub dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;             // 40 ns period
    end

    // --------------------
    // Helpers
    // --------------------
    function automatic logic [31:0] rand_word();
        rand_word = $random(seed);
    endfunction

    function automatic int rand_len();
        logic [31:0] r;
        r = rand_word();
        return 1 + int'(r[2:0]);            // 1 to 8 beats
    endfunction

    function automatic beat_t make_beat(input logic last);
        beat_t       b;
        logic [31:0] r;
        r       = rand_word();
        b.tdata = {rand_word(), rand_word()};
        b.tstrb = r[7:0];
        b.tuser = {rand_word(), rand_word(), rand_word(), rand_word()};    // Junk source field
        b.tlast = last;
        return b;
    endfunction

    // Host sees the beat unchanged except for the port code in tuser
    function automatic beat_t expected_rx_beat(input beat_t b, input port_sel_t p);
        beat_t e;
        e = b;
        if (p == PORT_A) begin
            e.tuser[`HUB_SRC_LSB +: `HUB_SRC_W] = `HUB_PORT_A_CODE;
        end else begin
            e.tuser[`HUB_SRC_LSB +: `HUB_SRC_W] = `HUB_PORT_D_CODE;
        end
        return e;
    endfunction

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic report_problem(input string msg);
        other_count++;
        $display("Error at %0t: %s", $time, msg);
    endtask

    task automatic compare_beat(input string port, input beat_t got, input beat_t exp);
        check_value({port, "_tdata"}, 128'(got.tdata), 128'(exp.tdata));
        check_value({port, "_tstrb"}, 128'(got.tstrb), 128'(exp.tstrb));
        check_value({port, "_tuser"}, 128'(got.tuser), 128'(exp.tuser));
        check_value({port, "_tlast"}, 128'(got.tlast), 128'(exp.tlast));
    endtask

    task automatic print_counts();
        $display("Errors: %0d value mismatches, %0d other failures", mismatch_count, other_count);
    endtask

    // --------------------
    // Drivers
    // --------------------
    task automatic present_rx(input port_sel_t p, input logic v, input beat_t b);
        if (p == PORT_A) begin
            a_rx_tvalid <= v;
            a_rx_tdata  <= b.tdata;
            a_rx_tstrb  <= b.tstrb;
            a_rx_tuser  <= b.tuser;
            a_rx_tlast  <= b.tlast;
        end else begin
            d_rx_tvalid <= v;
            d_rx_tdata  <= b.tdata;
            d_rx_tstrb  <= b.tstrb;
            d_rx_tuser  <= b.tuser;
            d_rx_tlast  <= b.tlast;
        end
    endtask

    function automatic logic rx_ready_of(input port_sel_t p);
        return (p == PORT_A) ? a_rx_tready : d_rx_tready;
    endfunction

    task automatic stop_rx(input port_sel_t p);
        if (p == PORT_A) begin
            a_rx_tvalid <= 1'b0;
        end else begin
            d_rx_tvalid <= 1'b0;
        end
    endtask

    // Valid stays high across packets unless gaps are asked for
    task automatic send_rx_packet(input port_sel_t p, input logic gaps);
        int          len;
        int          i;
        beat_t       b;
        logic [31:0] r;
        len = rand_len();
        for (i = 0; i < len; i++) begin
            b = make_beat(i == len - 1);
            if (p == PORT_A) begin
                exp_a_q.push_back(expected_rx_beat(b, p));
            end else begin
                exp_d_q.push_back(expected_rx_beat(b, p));
            end
            r = rand_word();
            if (gaps && r[1:0] != 2'b00) begin
                present_rx(p, 1'b0, b);     // Idle for 1 to 3 cycles
                repeat (int'(r[1:0])) @(posedge clk);
            end
            present_rx(p, 1'b1, b);
            @(posedge clk);
            while (!rx_ready_of(p)) begin
                @(posedge clk);             // Hold until merge takes it
            end
        end
    endtask

    task automatic send_tx_packet();
        int          len;
        int          i;
        beat_t       b;
        logic [31:0] r;
        len = rand_len();
        for (i = 0; i < len; i++) begin
            b = make_beat(i == len - 1);
            exp_atx_q.push_back(b);         // Same beat on both MACs
            exp_dtx_q.push_back(b);
            r = rand_word();
            if (r[1:0] != 2'b00) begin
                host_tx_tvalid <= 1'b0;
                repeat (int'(r[1:0])) @(posedge clk);
            end
            host_tx_tvalid <= 1'b1;
            host_tx_tdata  <= b.tdata;
            host_tx_tstrb  <= b.tstrb;
            host_tx_tuser  <= b.tuser;
            host_tx_tlast  <= b.tlast;
            @(posedge clk);
            while (!host_tx_tready) begin
                @(posedge clk);             // Both ports must be done
            end
        end
    endtask

    task automatic wait_drained();
        while (exp_a_q.size() != 0 || exp_d_q.size() != 0 ||
               exp_atx_q.size() != 0 || exp_dtx_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);          // Room for stray extra beats
    endtask

    task automatic check_quiet();
        check_value("host_rx_tvalid", 128'(host_rx_tvalid), 128'h0);
        check_value("a_tx_tvalid", 128'(a_tx_tvalid), 128'h0);
        check_value("d_tx_tvalid", 128'(d_tx_tvalid), 128'h0);
    endtask

    // --------------------
    // Ready generators
    // --------------------
    initial begin
        logic [31:0] r;
        host_rx_tready <= 1'b0;
        a_tx_tready    <= 1'b0;
        d_tx_tready    <= 1'b0;
        forever begin
            @(posedge clk);
            r = rand_word();
            host_rx_tready <= rx_ready_random ? r[0] : 1'b1;
            a_tx_tready    <= r[1] | r[2];  // About 3 in 4 cycles
            d_tx_tready    <= r[3];         // About 1 in 2 and independent of A
        end
    end

    // --------------------
    // Output checkers
    // --------------------
    task automatic check_rx_beat();
        beat_t      got;
        logic [7:0] src;
        got.tdata = host_rx_tdata;
        got.tstrb = host_rx_tstrb;
        got.tuser = host_rx_tuser;
        got.tlast = host_rx_tlast;
        src       = host_rx_tuser[`HUB_SRC_LSB +: `HUB_SRC_W];
        if (rx_in_packet && src != rx_cur_src) begin
            report_problem("host_rx switched source port inside a packet");
        end
        if (!rx_in_packet && alternate_on && rx_have_last && src == rx_last_src) begin
            report_problem("host_rx sent two packets in a row from one busy port");
        end
        if (src == `HUB_PORT_A_CODE && exp_a_q.size() != 0) begin
            compare_beat("host_rx", got, exp_a_q.pop_front());
        end else if (src == `HUB_PORT_D_CODE && exp_d_q.size() != 0) begin
            compare_beat("host_rx", got, exp_d_q.pop_front());
        end else begin
            report_problem("host_rx delivered a beat that no port has pending");
        end
        rx_cur_src   = src;
        rx_in_packet = !got.tlast;
        if (got.tlast) begin
            rx_last_src  = src;
            rx_have_last = 1'b1;
        end
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            if (host_rx_tvalid && host_rx_tready) begin
                check_rx_beat();
            end
            if (a_tx_tvalid && a_tx_tready) begin
                if (exp_atx_q.size() == 0) begin
                    report_problem("a_tx delivered a beat that the host never sent");
                end else begin
                    compare_beat("a_tx", '{a_tx_tdata, a_tx_tstrb, a_tx_tuser, a_tx_tlast},
                                 exp_atx_q.pop_front());
                end
            end
            if (d_tx_tvalid && d_tx_tready) begin
                if (exp_dtx_q.size() == 0) begin
                    report_problem("d_tx delivered a beat that the host never sent");
                end else begin
                    compare_beat("d_tx", '{d_tx_tdata, d_tx_tstrb, d_tx_tuser, d_tx_tlast},
                                 exp_dtx_q.pop_front());
                end
            end
        end
    end

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        rst            <= 1'b1;
        a_rx_tvalid    <= 1'b0;
        a_rx_tdata     <= '0;
        a_rx_tstrb     <= '0;
        a_rx_tuser     <= '0;
        a_rx_tlast     <= 1'b0;
        d_rx_tvalid    <= 1'b0;
        d_rx_tdata     <= '0;
        d_rx_tstrb     <= '0;
        d_rx_tuser     <= '0;
        d_rx_tlast     <= 1'b0;
        host_tx_tvalid <= 1'b0;
        host_tx_tdata  <= '0;
        host_tx_tstrb  <= '0;
        host_tx_tuser  <= '0;
        host_tx_tlast  <= 1'b0;
        repeat (10) begin
            @(posedge clk);
            check_quiet();                  // Nothing offered during reset
        end
        rst <= 1'b0;
        @(posedge clk);
        check_quiet();

        // Single packet per port for stamping
        send_rx_packet(PORT_A, 1'b0);
        stop_rx(PORT_A);
        wait_drained();
        send_rx_packet(PORT_D, 1'b0);
        stop_rx(PORT_D);
        wait_drained();

        // Both ports back to back with host always ready
        alternate_on = 1'b1;
        fork
            begin
                repeat (N_STREAM) send_rx_packet(PORT_A, 1'b0);
                stop_rx(PORT_A);
            end
            begin
                repeat (N_STREAM) send_rx_packet(PORT_D, 1'b0);
                stop_rx(PORT_D);
            end
        join
        wait_drained();
        alternate_on = 1'b0;

        // Random gaps and host back-pressure with broadcast alongside
        rx_ready_random = 1'b1;
        fork
            begin
                repeat (N_RANDOM) send_rx_packet(PORT_A, 1'b1);
                stop_rx(PORT_A);
            end
            begin
                repeat (N_RANDOM) send_rx_packet(PORT_D, 1'b1);
                stop_rx(PORT_D);
            end
            begin
                repeat (N_TX) send_tx_packet();
                host_tx_tvalid <= 1'b0;
            end
        join
        wait_drained();

        print_counts();
        if (mismatch_count == 0 && other_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Watchdog bound taken from the longest possible run
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Run timed out after %0d cycles with %0d receive and %0d transmit beats pending",
                 TIMEOUT_CYCLES, exp_a_q.size() + exp_d_q.size(),
                 exp_atx_q.size() + exp_dtx_q.size());
        print_counts();
        $display("Simulation failed");
        $finish;
    end

endmodule

/* design/packet_hub.sv */
// --------------------
// Packet hub top, single clock clk, synchronous reset rst
// Merges MAC A and D receive into host_rx, copies host_tx to both MACs
// --------------------
`timescale 1ns/1ps
`include "hub_config.svh"

module packet_hub (
    input  logic                   clk,
    input  logic                   rst,
    // MAC A receive
    input  logic [`HUB_DATA_W-1:0] a_rx_tdata,
    input  logic [`HUB_STRB_W-1:0] a_rx_tstrb,
    input  logic [`HUB_USER_W-1:0] a_rx_tuser,
    input  logic                   a_rx_tlast,
    input  logic                   a_rx_tvalid,
    output logic                   a_rx_tready,
    // MAC D receive
    input  logic [`HUB_DATA_W-1:0] d_rx_tdata,
    input  logic [`HUB_STRB_W-1:0] d_rx_tstrb,
    input  logic [`HUB_USER_W-1:0] d_rx_tuser,
    input  logic                   d_rx_tlast,
    input  logic                   d_rx_tvalid,
    output logic                   d_rx_tready,
    // Merged stream to DMA
    output logic [`HUB_DATA_W-1:0] host_rx_tdata,
    output logic [`HUB_STRB_W-1:0] host_rx_tstrb,
    output logic [`HUB_USER_W-1:0] host_rx_tuser,
    output logic                   host_rx_tlast,
    output logic                   host_rx_tvalid,
    input  logic                   host_rx_tready,
    // Transmit stream from DMA
    input  logic [`HUB_DATA_W-1:0] host_tx_tdata,
    input  logic [`HUB_STRB_W-1:0] host_tx_tstrb,
    input  logic [`HUB_USER_W-1:0] host_tx_tuser,
    input  logic                   host_tx_tlast,
    input  logic                   host_tx_tvalid,
    output logic                   host_tx_tready,
    // MAC A transmit
    output logic [`HUB_DATA_W-1:0] a_tx_tdata,
    output logic [`HUB_STRB_W-1:0] a_tx_tstrb,
    output logic [`HUB_USER_W-1:0] a_tx_tuser,
    output logic                   a_tx_tlast,
    output logic                   a_tx_tvalid,
    input  logic                   a_tx_tready,
    // MAC D transmit
    output logic [`HUB_DATA_W-1:0] d_tx_tdata,
    output logic [`HUB_STRB_W-1:0] d_tx_tstrb,
    output logic [`HUB_USER_W-1:0] d_tx_tuser,
    output logic                   d_tx_tlast,
    output logic                   d_tx_tvalid,
    input  logic                   d_tx_tready
);

    stream_if a_rx_if ();               // MAC A into merge
    stream_if d_rx_if ();               // MAC D into merge
    stream_if host_rx_if ();            // Merge out
    stream_if host_tx_if ();            // Host into fanout
    stream_if a_tx_if ();               // Fanout copy A
    stream_if d_tx_if ();               // Fanout copy D

    // --------------------
    // Receive side
    // --------------------
    assign a_rx_if.tvalid     = a_rx_tvalid;
    assign a_rx_if.beat.tdata = a_rx_tdata;
    assign a_rx_if.beat.tstrb = a_rx_tstrb;
    assign a_rx_if.beat.tuser = a_rx_tuser;
    assign a_rx_if.beat.tlast = a_rx_tlast;
    assign a_rx_tready        = a_rx_if.tready;

    assign d_rx_if.tvalid     = d_rx_tvalid;
    assign d_rx_if.beat.tdata = d_rx_tdata;
    assign d_rx_if.beat.tstrb = d_rx_tstrb;
    assign d_rx_if.beat.tuser = d_rx_tuser;
    assign d_rx_if.beat.tlast = d_rx_tlast;
    assign d_rx_tready        = d_rx_if.tready;

    stream_merge merge0 (
        .clk  (clk),
        .rst  (rst),
        .in_a (a_rx_if),
        .in_d (d_rx_if),
        .out  (host_rx_if)
    );

    assign host_rx_tvalid    = host_rx_if.tvalid;
    assign host_rx_tdata     = host_rx_if.beat.tdata;
    assign host_rx_tstrb     = host_rx_if.beat.tstrb;
    assign host_rx_tuser     = host_rx_if.beat.tuser;   // Source field stamped
    assign host_rx_tlast     = host_rx_if.beat.tlast;
    assign host_rx_if.tready = host_rx_tready;

    // --------------------
    // Transmit side
    // --------------------
    assign host_tx_if.tvalid     = host_tx_tvalid;
    assign host_tx_if.beat.tdata = host_tx_tdata;
    assign host_tx_if.beat.tstrb = host_tx_tstrb;
    assign host_tx_if.beat.tuser = host_tx_tuser;
    assign host_tx_if.beat.tlast = host_tx_tlast;
    assign host_tx_tready        = host_tx_if.tready;   // Both MACs done

    stream_fanout fanout0 (
        .clk   (clk),
        .rst   (rst),
        .in    (host_tx_if),
        .out_a (a_tx_if),
        .out_d (d_tx_if)
    );

    assign a_tx_tvalid    = a_tx_if.tvalid;
    assign a_tx_tdata     = a_tx_if.beat.tdata;
    assign a_tx_tstrb     = a_tx_if.beat.tstrb;
    assign a_tx_tuser     = a_tx_if.beat.tuser;
    assign a_tx_tlast     = a_tx_if.beat.tlast;
    assign a_tx_if.tready = a_tx_tready;

    assign d_tx_tvalid    = d_tx_if.tvalid;
    assign d_tx_tdata     = d_tx_if.beat.tdata;
    assign d_tx_tstrb     = d_tx_if.beat.tstrb;
    assign d_tx_tuser     = d_tx_if.beat.tuser;
    assign d_tx_tlast     = d_tx_if.beat.tlast;
    assign d_tx_if.tready = d_tx_tready;

endmodule

/* design/stream_fanout.sv */
// --------------------
// One-to-two packet broadcast with zero latency
// Host sees ready once both ports have taken the beat
// --------------------
`timescale 1ns/1ps

module stream_fanout (
    input  logic     clk,
    input  logic     rst,
    stream_if.sink   in,                // Host transmit stream
    stream_if.source out_a,             // Copy toward MAC A
    stream_if.source out_d              // Copy toward MAC D
);

    logic done_a_q;                     // A already took current beat
    logic done_d_q;                     // D already took current beat
    logic take_a;                       // A takes the beat this cycle
    logic take_d;
    logic all_done;                     // Both copies delivered

    // --------------------
    // Per-port offer
    // --------------------
    assign out_a.tvalid = in.tvalid && !done_a_q;   // Never offered twice
    assign out_d.tvalid = in.tvalid && !done_d_q;
    assign out_a.beat   = in.beat;
    assign out_d.beat   = in.beat;

    assign take_a = out_a.tvalid && out_a.tready;
    assign take_d = out_d.tvalid && out_d.tready;

    // Each port done earlier or done now
    assign all_done = (done_a_q || take_a) && (done_d_q || take_d);
    assign in.tready = all_done;

    // --------------------
    // Delivered flags
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            done_a_q <= 1'b0;
            done_d_q <= 1'b0;
        end else if (in.tvalid && all_done) begin
            done_a_q <= 1'b0;           // Host moves to next beat
            done_d_q <= 1'b0;
        end else begin
            done_a_q <= done_a_q || take_a;
            done_d_q <= done_d_q || take_d;
        end
    end

    // --------------------
    // Checks
    // --------------------
    // A stalled port keeps its offer until it takes the beat
    a_port_hold_a: assert property (@(posedge clk) disable iff (rst)
        out_a.tvalid && !out_a.tready |=> out_a.tvalid && $stable(out_a.beat));

    a_port_hold_d: assert property (@(posedge clk) disable iff (rst)
        out_d.tvalid && !out_d.tready |=> out_d.tvalid && $stable(out_d.beat));

    // Flags only make sense if the host holds its beat
    a_host_hold: assert property (@(posedge clk) disable iff (rst)
        in.tvalid && !in.tready |=> in.tvalid && $stable(in.beat));

endmodule

/* design/stream_merge.sv */
// --------------------
// Two-to-one packet merge with zero latency and round robin per packet
// Grant is locked from first offered beat to the tlast transfer
// Source field in tuser is overwritten with the port code
// --------------------
`timescale 1ns/1ps
`include "hub_config.svh"

module stream_merge (
    input  logic     clk,
    input  logic     rst,
    stream_if.sink   in_a,              // Receive stream of MAC A
    stream_if.sink   in_d,              // Receive stream of MAC D
    stream_if.source out                // Merged stream toward DMA
);
    import hub_pkg::*;

    port_sel_t grant_q;                 // Port locked for current packet
    port_sel_t last_q;                  // Port that sent the last packet
    logic      active_q;                // Packet in flight or beat on offer
    port_sel_t pref;                    // Round-robin favourite
    logic      pref_valid;
    port_sel_t sel;                     // Port driving the output now
    logic      sel_valid;
    beat_t     sel_beat;                // Granted beat with port code
    logic      xfer;                    // Output handshake

    // --------------------
    // Arbitration
    // --------------------
    assign pref       = (last_q == PORT_A) ? PORT_D : PORT_A;
    assign pref_valid = (pref == PORT_A) ? in_a.tvalid : in_d.tvalid;

    always_comb begin
        if (active_q) begin
            sel = grant_q;              // Locked until tlast goes out
        end else if (pref_valid) begin
            sel = pref;
        end else if (in_a.tvalid) begin
            sel = PORT_A;               // Only A is asking
        end else if (in_d.tvalid) begin
            sel = PORT_D;               // Only D is asking
        end else begin
            sel = pref;                 // Idle with nothing granted
        end
    end

    // --------------------
    // Data mux and stamping
    // --------------------
    always_comb begin
        if (sel == PORT_A) begin
            sel_valid = in_a.tvalid;
            sel_beat  = in_a.beat;
            sel_beat.tuser[`HUB_SRC_LSB +: `HUB_SRC_W] = `HUB_PORT_A_CODE;
        end else begin
            sel_valid = in_d.tvalid;
            sel_beat  = in_d.beat;
            sel_beat.tuser[`HUB_SRC_LSB +: `HUB_SRC_W] = `HUB_PORT_D_CODE;
        end
    end

    assign out.tvalid = sel_valid;
    assign out.beat   = sel_beat;
    assign xfer       = sel_valid && out.tready;

    // Ready goes back to the granted port only
    assign in_a.tready = out.tready && sel_valid && (sel == PORT_A);
    assign in_d.tready = out.tready && sel_valid && (sel == PORT_D);

    // --------------------
    // Grant state
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            active_q <= 1'b0;
            grant_q  <= PORT_A;
            last_q   <= PORT_D;         // So A wins the first packet
        end else begin
            if (!active_q && sel_valid) begin
                grant_q <= sel;         // Lock on the first offered beat
            end
            if (xfer && sel_beat.tlast) begin
                active_q <= 1'b0;       // Rearbitrate after tlast
                last_q   <= sel;
            end else if (sel_valid) begin
                active_q <= 1'b1;
            end
        end
    end

    // --------------------
    // Checks
    // --------------------
    // Stalled output must not change under the DMA
    a_out_hold: assert property (@(posedge clk) disable iff (rst)
        out.tvalid && !out.tready |=> out.tvalid && $stable(out.beat));

    // Other port gets no ready once a packet has started
    a_grant_hold_a: assert property (@(posedge clk) disable iff (rst)
        in_a.tvalid && in_a.tready && !in_a.beat.tlast |=> !in_d.tready);

    a_grant_hold_d: assert property (@(posedge clk) disable iff (rst)
        in_d.tvalid && in_d.tready && !in_d.beat.tlast |=> !in_a.tready);

endmodule

/* design/stream_if.sv */
// --------------------
// One valid/ready packet stream, no clock inside
// Source holds tvalid and beat until tready is seen
// --------------------
`timescale 1ns/1ps

interface stream_if;
    import hub_pkg::*;

    logic  tvalid;                      // Beat on offer
    logic  tready;                      // Sink takes the beat
    beat_t beat;                        // Data, strobe, sideband, last

    // Producer side
    modport source (
        output tvalid,
        output beat,
        input  tready
    );

    // Consumer side
    modport sink (
        input  tvalid,
        input  beat,
        output tready
    );

endinterface

/* design/hub_pkg.sv */
// --------------------
// Stream beat and port select types
// Widths come from the config header
// --------------------
`include "hub_config.svh"

package hub_pkg;

    // --------------------
    // One beat of a packet stream
    // --------------------
    typedef struct packed {
        logic [`HUB_DATA_W-1:0] tdata;  // Payload
        logic [`HUB_STRB_W-1:0] tstrb;  // Valid bytes
        logic [`HUB_USER_W-1:0] tuser;  // Sideband, holds source port
        logic                   tlast;  // Last beat of packet
    } beat_t;

    // --------------------
    // MAC port naming
    // --------------------
    typedef enum logic {
        PORT_A = 1'b0,                  // First MAC
        PORT_D = 1'b1                   // Second MAC
    } port_sel_t;

endpackage

/* design/hub_config.svh */
// --------------------
// Stream widths and port codes of the hub, one clock domain
// Source field must fit inside tuser at HUB_SRC_LSB
// --------------------
`ifndef HUB_CONFIG_SVH
`define HUB_CONFIG_SVH

// Beat widths ----------
`define HUB_DATA_W      64          // 10G datapath width
`define HUB_STRB_W      8           // One strobe bit per byte
`define HUB_USER_W      128         // DMA sideband

// Source-port field ----
`define HUB_SRC_LSB     16          // Field sits in tuser[23:16]
`define HUB_SRC_W       8
`define HUB_PORT_A_CODE 8'h02       // Stamped on port A packets
`define HUB_PORT_D_CODE 8'h80       // Stamped on port D packets

`endif
